//--- bomb_pkg.sv
package bomb_pkg;

  // ======================================================================
  // tile codes and widths
  // ======================================================================
  typedef logic [1:0]  tile_t;      // one map cell
  typedef logic [10:0] px_x_t;      // player x, top-left pixel
  typedef logic [9:0]  px_y_t;      // player y, top-left pixel
  typedef logic [7:0]  map_addr_t;  // row * NUM_COL + col
  typedef logic [3:0]  row_t;       // 0 .. NUM_ROW-1
  typedef logic [4:0]  col_t;       // 0 .. NUM_COL-1

  localparam tile_t TILE_FLOOR = 2'd0;
  localparam tile_t TILE_WALL  = 2'd1;
  localparam tile_t TILE_BRICK = 2'd2;
  localparam tile_t TILE_BOMB  = 2'd3;

  // grid and pixel geometry
  localparam int NUM_ROW    = 11;
  localparam int NUM_COL    = 19;
  localparam int NUM_TILES  = NUM_ROW * NUM_COL;  // 209
  localparam int TILE_PX    = 64;
  localparam int TILE_SHIFT = $clog2(TILE_PX);    // px -> tile index
  localparam int SPRITE_W   = 32;

  // ======================================================================
  // layout helpers
  // ======================================================================
  function automatic map_addr_t tile_addr(row_t r, col_t c);
    return map_addr_t'(int'(r) * NUM_COL + int'(c));
  endfunction

  // fixed start layout, border first, then pillars, then bricks
  function automatic tile_t layout_tile(row_t r, col_t c);
    if (r == 0 || int'(r) == NUM_ROW - 1 || c == 0 || int'(c) == NUM_COL - 1)
      return TILE_WALL;
    if (!r[0] && !c[0])
      return TILE_WALL;  // even/even pillar
    if (((int'(r) + int'(c)) % 4) == 1)
      return TILE_BRICK;
    return TILE_FLOOR;
  endfunction

endpackage

//--- frame_tick.sv
`timescale 1ns/100ps

module frame_tick #(
  parameter int tick_div = 16  // clocks per game tick
) (
  input  logic clk,
  input  logic rst,
  output logic tick
);

  // at least one bit even for tick_div of 1
  localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

  logic [cnt_w-1:0] div_cnt;  // clocks since last tick
  logic             wrap;

  assign wrap = (div_cnt == cnt_w'(tick_div - 1));

  // ======================================================================
  // divider, tick is registered so it is clean and starts low
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else begin
      tick <= wrap;  // one clock wide
      if (wrap)
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

//--- map_mem.sv
`timescale 1ns/100ps

module map_mem (
  input  logic                clk,
  input  logic                rst,
  // bomb placement write, data is always the bomb code
  input  logic                place_we,
  input  bomb_pkg::map_addr_t place_addr,
  // blast write and read
  input  logic                blast_we,
  input  bomb_pkg::map_addr_t blast_wr_addr,
  input  bomb_pkg::tile_t     blast_wr_data,
  input  bomb_pkg::map_addr_t blast_rd_addr,
  output bomb_pkg::tile_t     blast_rd_data,
  // outside view port
  input  bomb_pkg::map_addr_t view_addr,
  output bomb_pkg::tile_t     view_data,
  output logic                map_ready
);

  bomb_pkg::tile_t mem [bomb_pkg::NUM_TILES];  // row-major tile grid

  // fill walk, address plus row/col so no divide is needed
  bomb_pkg::map_addr_t fill_addr;
  bomb_pkg::row_t      fill_row;
  bomb_pkg::col_t      fill_col;

  // merged write port
  logic                wr_en;
  bomb_pkg::map_addr_t wr_addr;
  bomb_pkg::tile_t     wr_data;

  // ======================================================================
  // layout fill after reset, one tile per clock
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      fill_addr <= '0;
      fill_row  <= '0;
      fill_col  <= '0;
      map_ready <= 1'b0;
    end else if (!map_ready) begin
      fill_addr <= fill_addr + 1'b1;
      if (int'(fill_col) == bomb_pkg::NUM_COL - 1) begin
        fill_col <= '0;  // next row
        fill_row <= fill_row + 1'b1;
      end else begin
        fill_col <= fill_col + 1'b1;
      end
      if (int'(fill_addr) == bomb_pkg::NUM_TILES - 1)
        map_ready <= 1'b1;  // last tile written this clock
    end
  end

  // ======================================================================
  // write arbitration
  // ======================================================================
  always_comb begin
    wr_en   = 1'b0;
    wr_addr = place_addr;
    wr_data = bomb_pkg::TILE_BOMB;
    if (!map_ready) begin
      wr_en   = 1'b1;  // fill owns the port, game writes dropped
      wr_addr = fill_addr;
      wr_data = bomb_pkg::layout_tile(fill_row, fill_col);
    end else if (blast_we) begin
      wr_en   = 1'b1;  // blast first
      wr_addr = blast_wr_addr;
      wr_data = blast_wr_data;
    end else if (place_we) begin
      wr_en   = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // ======================================================================
  // registered read ports, data one clock after address
  // ======================================================================
  always_ff @(posedge clk) begin
    blast_rd_data <= mem[blast_rd_addr];
    if (int'(view_addr) < bomb_pkg::NUM_TILES)
      view_data <= mem[view_addr];
    else
      view_data <= bomb_pkg::TILE_WALL;  // off the grid reads as wall
  end

endmodule

//--- bomb_logic.sv
`timescale 1ns/100ps

module bomb_logic #(
  parameter int  fuse_ticks = 12,  // ticks from placement to explosion
  localparam int cnt_w      = $clog2(fuse_ticks + 1)
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                tick,
  input  logic                map_ready,
  input  logic                blast_busy,
  input  bomb_pkg::px_x_t     player_x,
  input  bomb_pkg::px_y_t     player_y,
  input  logic                place_bomb,
  output logic                place_we,
  output bomb_pkg::map_addr_t place_addr,
  output bomb_pkg::map_addr_t bomb_addr,
  output logic                bomb_active,
  output logic [cnt_w-1:0]    countdown,
  output logic                trigger_explosion
);

  // offset limits in pixels
  localparam int off_y_lim = bomb_pkg::TILE_PX / 4;                          // 16
  localparam int off_x_lim = bomb_pkg::TILE_PX / 4 + bomb_pkg::SPRITE_W / 4; // 24

  // ======================================================================
  // player pixel position -> tile address
  // ======================================================================
  bomb_pkg::row_t                      base_row;
  bomb_pkg::col_t                      base_col;
  logic [bomb_pkg::TILE_SHIFT-1:0]     off_x;  // pixels into the tile
  logic [bomb_pkg::TILE_SHIFT-1:0]     off_y;

  assign base_row = bomb_pkg::row_t'(player_y >> bomb_pkg::TILE_SHIFT);
  assign base_col = bomb_pkg::col_t'(player_x >> bomb_pkg::TILE_SHIFT);
  assign off_x    = player_x[bomb_pkg::TILE_SHIFT-1:0];
  assign off_y    = player_y[bomb_pkg::TILE_SHIFT-1:0];

  // most of the sprite hangs into the next tile -> use that tile
  always_comb begin
    place_addr = bomb_pkg::tile_addr(base_row, base_col);
    if (int'(off_y) > off_y_lim)
      place_addr = bomb_pkg::tile_addr(bomb_pkg::row_t'(base_row + 1), base_col);
    else if (int'(off_x) > off_x_lim)
      place_addr = bomb_pkg::tile_addr(base_row, bomb_pkg::col_t'(base_col + 1));
  end

  // ======================================================================
  // single bomb, placement and fuse
  // ======================================================================
  logic armed;      // fuse running
  logic fuse_fire;  // last fuse tick

  // capacity of one: busy while fuse runs or blast is clearing
  assign bomb_active = armed | blast_busy;

  // placement only on a tick, only when idle and the map is loaded
  assign place_we = tick & place_bomb & ~bomb_active & map_ready;

  assign fuse_fire         = tick & armed & (countdown == cnt_w'(1));
  assign trigger_explosion = fuse_fire;  // one clock, tick is one clock

  always_ff @(posedge clk) begin
    if (rst) begin
      armed     <= 1'b0;
      countdown <= '0;
    end else if (place_we) begin
      armed     <= 1'b1;
      countdown <= cnt_w'(fuse_ticks);
    end else if (fuse_fire) begin
      armed     <= 1'b0;  // blast_busy takes over from here
      countdown <= '0;
    end else if (tick && armed) begin
      countdown <= countdown - 1'b1;
    end
  end

  // bomb tile, held for the blast
  always_ff @(posedge clk) begin
    if (place_we)
      bomb_addr <= place_addr;
  end

endmodule

//--- blast_clear.sv
`timescale 1ns/100ps

module blast_clear (
  input  logic                clk,
  input  logic                rst,
  input  logic                trigger_explosion,
  input  bomb_pkg::map_addr_t bomb_addr,
  input  bomb_pkg::tile_t     blast_rd_data,
  output bomb_pkg::map_addr_t blast_rd_addr,
  output logic                blast_we,
  output bomb_pkg::map_addr_t blast_wr_addr,
  output bomb_pkg::tile_t     blast_wr_data,
  output logic                blast_busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,   // address out, data next clock
    st_write   // data back, write cleared tile
  } state_t;

  typedef enum logic [2:0] {
    step_centre,
    step_up,
    step_down,
    step_left,
    step_right
  } step_t;

  state_t state;
  step_t  step;

  bomb_pkg::row_t      ctr_row;  // bomb tile position
  bomb_pkg::col_t      ctr_col;
  bomb_pkg::map_addr_t cur_addr;

  // ======================================================================
  // tile under visit
  // ======================================================================
  always_comb begin
    case (step)
      step_up:    cur_addr = bomb_pkg::tile_addr(bomb_pkg::row_t'(ctr_row - 1), ctr_col);
      step_down:  cur_addr = bomb_pkg::tile_addr(bomb_pkg::row_t'(ctr_row + 1), ctr_col);
      step_left:  cur_addr = bomb_pkg::tile_addr(ctr_row, bomb_pkg::col_t'(ctr_col - 1));
      step_right: cur_addr = bomb_pkg::tile_addr(ctr_row, bomb_pkg::col_t'(ctr_col + 1));
      default:    cur_addr = bomb_pkg::tile_addr(ctr_row, ctr_col);
    endcase
  end

  assign blast_rd_addr = cur_addr;
  assign blast_wr_addr = cur_addr;
  assign blast_we      = (state == st_write);
  assign blast_busy    = (state != st_idle);  // 5 tiles x 2 clocks

  // centre and bricks become floor, walls and floor written back as read
  always_comb begin
    if (step == step_centre || blast_rd_data == bomb_pkg::TILE_BRICK)
      blast_wr_data = bomb_pkg::TILE_FLOOR;
    else
      blast_wr_data = blast_rd_data;
  end

  // ======================================================================
  // walk centre, up, down, left, right
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      step  <= step_centre;
    end else begin
      case (state)
        st_idle: begin
          if (trigger_explosion) begin
            state <= st_read;
            step  <= step_centre;
          end
        end
        st_read:  state <= st_write;
        st_write: begin
          state <= st_read;
          case (step)
            step_centre: step <= step_up;
            step_up:     step <= step_down;
            step_down:   step <= step_left;
            step_left:   step <= step_right;
            default: begin
              state <= st_idle;  // last neighbour done
              step  <= step_centre;
            end
          endcase
        end
        default: state <= st_idle;
      endcase
    end
  end

  // split bomb address once, never a border tile so neighbours stay on grid
  always_ff @(posedge clk) begin
    if (state == st_idle && trigger_explosion) begin
      ctr_row <= bomb_pkg::row_t'(int'(bomb_addr) / bomb_pkg::NUM_COL);
      ctr_col <= bomb_pkg::col_t'(int'(bomb_addr) % bomb_pkg::NUM_COL);
    end
  end

endmodule

//--- bomb_top.sv
`timescale 1ns/100ps

module bomb_top #(
  parameter int  tick_div   = 16,  // clocks per game tick
  parameter int  fuse_ticks = 12,  // ticks to explosion
  localparam int cnt_w      = $clog2(fuse_ticks + 1)
) (
  input  logic                clk,
  input  logic                rst,
  input  bomb_pkg::px_x_t     player_x,
  input  bomb_pkg::px_y_t     player_y,
  input  logic                place_bomb,
  input  bomb_pkg::map_addr_t view_addr,
  output bomb_pkg::tile_t     view_data,
  output logic                map_ready,
  output logic                bomb_active,
  output logic [cnt_w-1:0]    countdown,
  output logic                trigger_explosion,
  output logic                blast_busy
);

  // ======================================================================
  // internal nets
  // ======================================================================
  logic                tick;
  logic                place_we;
  bomb_pkg::map_addr_t place_addr;
  bomb_pkg::map_addr_t bomb_addr;     // latched at placement
  bomb_pkg::map_addr_t blast_rd_addr;
  bomb_pkg::tile_t     blast_rd_data;
  logic                blast_we;
  bomb_pkg::map_addr_t blast_wr_addr;
  bomb_pkg::tile_t     blast_wr_data;

  frame_tick #(.tick_div(tick_div)) u_tick (
    .clk  (clk),
    .rst  (rst),
    .tick (tick)
  );

  map_mem u_map (
    .clk           (clk),
    .rst           (rst),
    .place_we      (place_we),
    .place_addr    (place_addr),
    .blast_we      (blast_we),
    .blast_wr_addr (blast_wr_addr),
    .blast_wr_data (blast_wr_data),
    .blast_rd_addr (blast_rd_addr),
    .blast_rd_data (blast_rd_data),
    .view_addr     (view_addr),
    .view_data     (view_data),
    .map_ready     (map_ready)
  );

  bomb_logic #(.fuse_ticks(fuse_ticks)) u_bomb (
    .clk               (clk),
    .rst               (rst),
    .tick              (tick),
    .map_ready         (map_ready),
    .blast_busy        (blast_busy),
    .player_x          (player_x),
    .player_y          (player_y),
    .place_bomb        (place_bomb),
    .place_we          (place_we),
    .place_addr        (place_addr),
    .bomb_addr         (bomb_addr),
    .bomb_active       (bomb_active),
    .countdown         (countdown),
    .trigger_explosion (trigger_explosion)
  );

  blast_clear u_blast (
    .clk               (clk),
    .rst               (rst),
    .trigger_explosion (trigger_explosion),
    .bomb_addr         (bomb_addr),
    .blast_rd_data     (blast_rd_data),
    .blast_rd_addr     (blast_rd_addr),
    .blast_we          (blast_we),
    .blast_wr_addr     (blast_wr_addr),
    .blast_wr_data     (blast_wr_data),
    .blast_busy        (blast_busy)
  );

endmodule

//--- bomb_assertions.sv
`timescale 1ns/100ps

module bomb_assertions #(
  parameter int  fuse_ticks = 12,
  localparam int cnt_w      = $clog2(fuse_ticks + 1)
) (
  input logic             clk,
  input logic             rst,
  input logic             tick,
  input logic             place_we,
  input logic             place_bomb,
  input logic             bomb_active,
  input logic [cnt_w-1:0] countdown,
  input logic             trigger_explosion,
  input logic             blast_busy
);

  int   fail_cnt = 0;  // number of failed assertions
  logic fuse_on;       // bomb placed and not yet exploded
  int   ticks_since;   // ticks after the placement tick
  int   busy_len;      // clocks of the running blast

  task automatic count_failure(input string msg);
    $error("%s", msg);
    fail_cnt++;
  endtask

  // ======================================================================
  // reference fuse and blast length
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      fuse_on     <= 1'b0;
      ticks_since <= 0;
    end else if (place_we) begin
      fuse_on     <= 1'b1;
      ticks_since <= 0;
    end else if (trigger_explosion) begin
      fuse_on <= 1'b0;
    end else if (tick && fuse_on) begin
      ticks_since <= ticks_since + 1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !blast_busy)
      busy_len <= 0;
    else
      busy_len <= busy_len + 1;
  end

  // ======================================================================
  // fuse timing, single bomb, blast timing
  // ======================================================================
  a_trig_pulse: assert property (@(posedge clk) disable iff (rst)
    trigger_explosion |=> !trigger_explosion)
    else count_failure("explosion pulse is longer than one clock");
  a_trig_when: assert property (@(posedge clk) disable iff (rst)
    trigger_explosion |-> fuse_on && tick && ticks_since == fuse_ticks - 1)
    else count_failure("explosion came without a bomb or on the wrong tick");
  a_trig_due: assert property (@(posedge clk) disable iff (rst)
    tick && fuse_on && ticks_since == fuse_ticks - 1 |-> trigger_explosion)
    else count_failure("fuse ran out but no explosion followed");
  a_cnt_max: assert property (@(posedge clk) disable iff (rst)
    int'(countdown) <= fuse_ticks)
    else count_failure("countdown went above the fuse length");
  a_no_second: assert property (@(posedge clk) disable iff (rst)
    tick && place_bomb && bomb_active |=> countdown != cnt_w'(fuse_ticks))
    else count_failure("strobe during an active bomb restarted the fuse");
  a_held: assert property (@(posedge clk) disable iff (rst)
    tick && place_bomb && bomb_active && !blast_busy |=> bomb_active &&
    (countdown == $past(countdown) - cnt_w'(1) || countdown == '0))
    else count_failure("strobe during a fuse disturbed the running bomb");
  a_busy_start: assert property (@(posedge clk) disable iff (rst)
    trigger_explosion |=> blast_busy)
    else count_failure("blast did not start the clock after the explosion");
  a_busy_len: assert property (@(posedge clk) disable iff (rst)
    $fell(blast_busy) |-> busy_len == 10 && !bomb_active)
    else count_failure("blast length is not 10 clocks or bomb stayed active");

endmodule

bind bomb_top bomb_assertions #(.fuse_ticks(fuse_ticks)) u_chk (.*);

//--- bomb_tb.sv
`timescale 1ns/100ps

module bomb_tb;

  localparam int tick_div   = 16;
  localparam int fuse_ticks = 12;
  localparam int num_bombs  = 8;
  localparam int cnt_w      = $clog2(fuse_ticks + 1);
  localparam int n_col      = 19;
  localparam int n_tiles    = 11 * 19;
  // fill, every fuse plus blast, then slack for the view reads
  localparam int max_clocks = n_tiles + num_bombs * (fuse_ticks + 2) * tick_div + 2000;

  logic                clk;
  logic                rst;
  bomb_pkg::px_x_t     player_x;
  bomb_pkg::px_y_t     player_y;
  logic                place_bomb;
  bomb_pkg::map_addr_t view_addr;
  bomb_pkg::tile_t     view_data;
  logic                map_ready;
  logic                bomb_active;
  logic [cnt_w-1:0]    countdown;
  logic                trigger_explosion;
  logic                blast_busy;

  bomb_pkg::tile_t model [n_tiles];  // expected map, follows every write
  int              err_cnt = 0;
  int              chk_cnt = 0;
  int              bomb_at;

  bomb_top #(.tick_div(tick_div), .fuse_ticks(fuse_ticks)) uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns
  end

  initial begin
    repeat (max_clocks) @(posedge clk);
    $display("timeout, run still busy after %0d clocks", max_clocks);
    $display("*** FAILED ***");
    $finish;
  end

  // ======================================================================
  // reference models
  // ======================================================================
  function automatic bomb_pkg::tile_t start_tile(int r, int c);
    if (r == 0 || r == 10 || c == 0 || c == n_col - 1)
      return 2'd1;  // border wall
    if (r % 2 == 0 && c % 2 == 0)
      return 2'd1;  // pillar
    return ((r + c) % 4 == 1) ? 2'd2 : 2'd0;
  endfunction

  // base tile, then below if low in it, else right if far right
  function automatic int predict_addr(int x, int y);
    int row;
    int col;
    row = y / 64;
    col = x / 64;
    if (y % 64 > 16)
      row++;
    else if (x % 64 > 24)
      col++;
    return row * n_col + col;
  endfunction

  // ======================================================================
  // view port reads
  // ======================================================================
  task automatic check_tile(input int addr);
    bomb_pkg::tile_t got;
    @(posedge clk);
    view_addr <= bomb_pkg::map_addr_t'(addr);
    @(posedge clk);  // registered read
    @(negedge clk);
    got = view_data;
    chk_cnt++;
    if (got !== model[addr]) begin
      err_cnt++;
      $display("CHECK FAILED view_data addr=%h got=%h exp=%h", addr, got, model[addr]);
    end
  endtask

  task automatic check_map();
    for (int a = 0; a < n_tiles; a++)
      check_tile(a);
  endtask

  // centre to floor, bricks around it to floor, then read all five
  task automatic check_blast(input int addr);
    int nb [5];
    nb = '{addr, addr - n_col, addr + n_col, addr - 1, addr + 1};
    model[addr] = 2'd0;
    foreach (nb[i]) begin
      if (model[nb[i]] == 2'd2)
        model[nb[i]] = 2'd0;
      check_tile(nb[i]);
    end
  endtask

  // random floor tile, reached from the left, from above or directly
  task automatic place_one(input int variant, output int addr);
    int r;
    int c;
    int x;
    int y;
    r = 0;
    c = 0;
    while (model[r * n_col + c] != 2'd0) begin
      r = 1 + $urandom % 9;
      c = 1 + $urandom % 17;
    end
    case (variant)
      1: begin  // low in the tile above
        y = (r - 1) * 64 + 17 + $urandom % 47;
        x = c * 64 + $urandom % 64;
      end
      2: begin  // far right in the tile to the left
        y = r * 64 + $urandom % 17;
        x = (c - 1) * 64 + 25 + $urandom % 39;
      end
      default: begin
        y = r * 64 + $urandom % 17;
        x = c * 64 + $urandom % 25;
      end
    endcase
    addr = predict_addr(x, y);
    @(posedge clk);
    player_x   <= bomb_pkg::px_x_t'(x);
    player_y   <= bomb_pkg::px_y_t'(y);
    place_bomb <= 1'b1;
    while (!bomb_active) @(negedge clk);
    repeat (3 * tick_div) @(posedge clk);  // extra strobes on live fuse
    place_bomb <= 1'b0;
    model[addr] = 2'd3;
    check_tile(addr);
  endtask

  // ======================================================================
  // main sequence
  // ======================================================================
  initial begin
    void'($urandom(22));
    rst        = 1'b1;
    place_bomb = 1'b0;
    player_x   = '0;
    player_y   = '0;
    view_addr  = '0;
    for (int a = 0; a < n_tiles; a++)
      model[a] = start_tile(a / n_col, a % n_col);
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    while (!map_ready) @(negedge clk);
    check_map();
    for (int i = 0; i < num_bombs; i++) begin
      place_one(i % 3, bomb_at);
      while (bomb_active) @(negedge clk);  // fuse and blast done
      check_blast(bomb_at);
    end
    check_map();
    $display("view checks %0d, mismatches %0d, assertion failures %0d",
             chk_cnt, err_cnt, uut.u_chk.fail_cnt);
    if (err_cnt == 0 && uut.u_chk.fail_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- tb.f
bomb_pkg.sv
frame_tick.sv
map_mem.sv
bomb_logic.sv
blast_clear.sv
bomb_top.sv
bomb_assertions.sv
bomb_tb.sv

//--- Makefile
SIM      = verilator
TOP      = bomb_tb
FILELIST = tb.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
